//--- Bender.yml
package:
  name: divUnit

sources:
  - rtl/divPkg.sv
  - rtl/divDecode.sv
  - rtl/divider.sv
  - rtl/divResult.sv
  - rtl/divUnit.sv
  - target: test
    files:
      - tests/divUnit_asserts.sv
      - tests/divUnitTb.sv

//--- rtl/divDecode.sv
// Divide request decode
`timescale 1ns/1ns
`default_nettype none

module divDecode (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          reqValid,
	output logic               reqReady,
	input  wire divPkg::func_t reqFunc,
	input  wire divPkg::word_t reqA,
	input  wire divPkg::word_t reqB,
	input  wire logic          abort,
	input  wire logic          idle,
	input  wire logic          resFree,
	output logic               ld,
	output logic               sgn,
	output logic               sgnus,
	output divPkg::word_t      a,
	output divPkg::word_t      b,
	output logic               selRem,
	output logic               illegal,
	output logic               issueIllegal
);
	import divPkg::*;

	// Holding slot for one accepted request
	logic  slotValid;
	func_t slotFunc;
	word_t slotA;
	word_t slotB;

	// Decoded controls of the slot contents
	logic decSgn;
	logic decSgnus;
	logic decRem;
	logic decIll;

	logic issue;
	// Remainder select of the operation now in the divider
	logic remIssued;

	always_comb begin
		case (slotFunc)
			FuncDiv:   {decSgn, decSgnus, decRem, decIll} = 4'b1000;
			FuncDivu:  {decSgn, decSgnus, decRem, decIll} = 4'b0000;
			FuncDivsu: {decSgn, decSgnus, decRem, decIll} = 4'b0100;
			FuncMod:   {decSgn, decSgnus, decRem, decIll} = 4'b1010;
			FuncModu:  {decSgn, decSgnus, decRem, decIll} = 4'b0010;
			FuncModsu: {decSgn, decSgnus, decRem, decIll} = 4'b0110;
			default:   {decSgn, decSgnus, decRem, decIll} = 4'b0001;
		endcase
	end

	// Issue needs an idle divider and an empty result slot
	// Nothing goes out in an abort cycle since the slot is being flushed
	assign issue = slotValid && idle && resFree && !abort;
	assign ld = issue && !decIll;
	// Illegal codes bypass the divider entirely
	assign issueIllegal = issue && decIll;

	// Slot empty means the next request can come in
	assign reqReady = !slotValid;

	assign sgn = decSgn;
	assign sgnus = decSgnus;
	assign a = slotA;
	assign b = slotB;
	assign illegal = decIll;
	// Held from ld until the next ld, so still valid at done
	assign selRem = remIssued;

	always_ff @(posedge clk) begin
		if (rst) begin
			slotValid <= 1'b0;
			remIssued <= 1'b0;
		end else begin
			if (issue || abort) begin
				slotValid <= 1'b0;
			end
			// A request taken in the abort cycle is new and survives the flush
			if (reqValid && reqReady) begin
				slotValid <= 1'b1;
			end
			if (ld) begin
				remIssued <= decRem;
			end
		end
	end

	// Request payload
	always_ff @(posedge clk) begin
		if (reqValid && reqReady) begin
			slotFunc <= reqFunc;
			slotA <= reqA;
			slotB <= reqB;
		end
	end

endmodule

`default_nettype wire

//--- rtl/divPkg.sv
// Divide unit shared definitions
`default_nettype none

package divPkg;

	// ============================================================
	// Widths
	// ============================================================

	// Operand, quotient and remainder width
	localparam int divWidth = 64;

	// One operand, quotient or remainder word
	typedef logic [divWidth-1:0] word_t;

	// Request function code
	typedef logic [2:0] func_t;

	// Iteration counter, holds divWidth plus one without wrapping
	typedef logic [7:0] cnt_t;

	// ============================================================
	// Function codes
	// ============================================================

	// Quotient forms
	// Signed by signed
	localparam func_t FuncDiv = 3'd0;
	// Unsigned by unsigned
	localparam func_t FuncDivu = 3'd1;
	// Signed dividend, unsigned divisor
	localparam func_t FuncDivsu = 3'd2;

	// Remainder forms, same signedness order as above
	localparam func_t FuncMod = 3'd3;
	localparam func_t FuncModu = 3'd4;
	localparam func_t FuncModsu = 3'd5;

	// Codes 6 and 7 are not assigned and get flagged as illegal

	// ============================================================
	// Divider FSM
	// ============================================================

	// DivIdle waits for ld
	// DivRun does the iterations plus the sign step
	// DivDone presents the answer for one cycle
	typedef enum logic [1:0] {
		DivIdle,
		DivRun,
		DivDone
	} divState_t;

endpackage

`default_nettype wire

//--- rtl/divResult.sv
// Divide result holding slot
`timescale 1ns/1ns
`default_nettype none

module divResult (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          done,
	input  wire divPkg::word_t qo,
	input  wire divPkg::word_t ro,
	input  wire logic          dvByZr,
	input  wire logic          selRem,
	input  wire logic          illegal,
	input  wire logic          issueIllegal,
	output logic               resFree,
	output logic               resValid,
	input  wire logic          resReady,
	output divPkg::word_t      resData,
	output logic               resDivByZero,
	output logic               resIllegal
);
	import divPkg::*;

	// Quotient or remainder, picked by the issued function
	word_t selWord;

	assign selWord = selRem ? ro : qo;

	// New work is only issued into an empty slot
	assign resFree = !resValid;

	// ============================================================
	// Handshake and flags
	// ============================================================

	// done and issueIllegal never overlap, both need resFree at issue
	always_ff @(posedge clk) begin
		if (rst) begin
			resValid <= 1'b0;
			resDivByZero <= 1'b0;
			resIllegal <= 1'b0;
		end else if (done) begin
			resValid <= 1'b1;
			resDivByZero <= dvByZr;
			resIllegal <= 1'b0;
		end else if (issueIllegal) begin
			resValid <= 1'b1;
			resDivByZero <= 1'b0;
			resIllegal <= illegal;
		end else if (resValid && resReady) begin
			// Consumed
			resValid <= 1'b0;
			resDivByZero <= 1'b0;
			resIllegal <= 1'b0;
		end
	end

	// Result word, zero for an illegal code
	always_ff @(posedge clk) begin
		if (done) begin
			resData <= selWord;
		end else if (issueIllegal) begin
			resData <= '0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/divUnit.sv
// Integer divide unit top
`timescale 1ns/1ns
`default_nettype none

module divUnit (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          abort,
	input  wire logic          reqValid,
	output logic               reqReady,
	input  wire divPkg::func_t reqFunc,
	input  wire divPkg::word_t reqA,
	input  wire divPkg::word_t reqB,
	output logic               resValid,
	input  wire logic          resReady,
	output divPkg::word_t      resData,
	output logic               resDivByZero,
	output logic               resIllegal
);
	import divPkg::*;

	// Decode to divider
	logic  ld;
	logic  sgn;
	logic  sgnus;
	word_t a;
	word_t b;
	logic  idle;

	// Decode to result
	logic selRem;
	logic illegal;
	logic issueIllegal;
	logic resFree;

	// Divider to result
	word_t qo;
	word_t ro;
	logic  dvByZr;
	logic  done;

	// ============================================================
	// Request decode, one pending slot
	// ============================================================

	divDecode i_decode (
		.clk(clk), .rst(rst),
		.reqValid(reqValid), .reqReady(reqReady), .reqFunc(reqFunc),
		.reqA(reqA), .reqB(reqB), .abort(abort),
		.idle(idle), .resFree(resFree),
		.ld(ld), .sgn(sgn), .sgnus(sgnus), .a(a), .b(b),
		.selRem(selRem), .illegal(illegal), .issueIllegal(issueIllegal)
	);

	// Shift-subtract core
	divider i_divider (
		.clk(clk), .rst(rst), .ld(ld), .abort(abort),
		.sgn(sgn), .sgnus(sgnus), .a(a), .b(b),
		.qo(qo), .ro(ro), .dvByZr(dvByZr), .done(done), .idle(idle)
	);

	// Output slot with back-pressure
	divResult i_result (
		.clk(clk), .rst(rst),
		.done(done), .qo(qo), .ro(ro), .dvByZr(dvByZr),
		.selRem(selRem), .illegal(illegal), .issueIllegal(issueIllegal),
		.resFree(resFree), .resValid(resValid), .resReady(resReady),
		.resData(resData), .resDivByZero(resDivByZero), .resIllegal(resIllegal)
	);

endmodule

`default_nettype wire

//--- rtl/divider.sv
// Restoring integer divider
`timescale 1ns/1ns
`default_nettype none

module divider (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          ld,
	input  wire logic          abort,
	input  wire logic          sgn,
	input  wire logic          sgnus,
	input  wire divPkg::word_t a,
	input  wire divPkg::word_t b,
	output divPkg::word_t      qo,
	output divPkg::word_t      ro,
	output logic               dvByZr,
	output logic               done,
	output logic               idle
);
	import divPkg::*;

	divState_t state;
	// Iterations left, zero selects the sign step
	cnt_t cnt;

	// ============================================================
	// Operand magnitudes
	// ============================================================

	logic  aNeg;
	logic  bNeg;
	word_t aMag;
	word_t bMag;

	// Dividend sign counts for both signed forms
	assign aNeg = (sgn || sgnus) && a[divWidth-1];
	// Divisor is only signed in the fully signed form
	assign bNeg = sgn && b[divWidth-1];
	// Most negative value maps onto itself, fine as unsigned magnitude
	assign aMag = aNeg ? -a : a;
	assign bMag = bNeg ? -b : b;

	// ============================================================
	// Datapath
	// ============================================================

	// Quotient shifts in from the right, dividend bits shift out the top
	word_t q;
	// Partial remainder
	word_t r;
	// Divisor magnitude
	word_t bb;
	// Output signs recorded at ld
	logic qNeg;
	logic rNeg;

	// Partial remainder with the next dividend bit appended
	logic [divWidth:0] rs;
	logic [divWidth:0] sub;
	logic              fits;
	word_t             rNext;

	assign rs = {r, q[divWidth-1]};
	assign sub = rs - {1'b0, bb};
	assign fits = rs >= {1'b0, bb};
	// Restoring step, keep the old value when the divisor doesn't fit
	// A zero divisor always fits, so q ends all ones and r ends as the dividend
	assign rNext = fits ? sub[divWidth-1:0] : rs[divWidth-1:0];

	assign idle = state == DivIdle;
	// Result registers are stable for this whole cycle
	assign done = state == DivDone;

	// ============================================================
	// FSM
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DivIdle;
			cnt <= '0;
			dvByZr <= 1'b0;
		end else begin
			case (state)
				DivIdle: begin
					if (ld && !abort) begin
						q <= aMag;
						bb <= bMag;
						r <= '0;
						qNeg <= aNeg ^ bNeg;
						// Remainder follows the dividend
						rNeg <= aNeg;
						dvByZr <= b == '0;
						cnt <= cnt_t'(divWidth);
						state <= DivRun;
					end
				end
				DivRun: begin
					if (abort) begin
						// Drop the operation, no done for it
						cnt <= '0;
						state <= DivIdle;
					end else if (cnt != '0) begin
						q <= {q[divWidth-2:0], fits};
						r <= rNext;
						cnt <= cnt - 1'b1;
					end else begin
						// Sign step
						qo <= qNeg ? -q : q;
						ro <= rNeg ? -r : r;
						state <= DivDone;
					end
				end
				DivDone: begin
					state <= DivIdle;
				end
				default: begin
					state <= DivIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src.f
rtl/divPkg.sv
rtl/divDecode.sv
rtl/divider.sv
rtl/divResult.sv
rtl/divUnit.sv
tests/divUnit_asserts.sv
tests/divUnitTb.sv

//--- tests/divUnitTb.sv
// Divide unit testbench
`timescale 1ns/1ns
`default_nettype none

module divUnitTb;
	import divPkg::*;

	// ============================================================
	// DUT signals
	// ============================================================

	logic  clk = 1'b0;
	logic  rst;
	logic  abort;
	logic  reqValid;
	logic  reqReady;
	func_t reqFunc;
	word_t reqA;
	word_t reqB;
	logic  resValid;
	logic  resReady;
	word_t resData;
	logic  resDivByZero;
	logic  resIllegal;

	// Vector table, one entry per data line
	logic [3:0] vMode[$];
	func_t      vFunc[$];
	word_t      vA[$];
	word_t      vB[$];
	word_t      vExp[$];
	logic       vDbz[$];
	logic       vIll[$];

	int   nVec = 0;
	logic loaded = 1'b0;
	// Requests that expect a result, and results taken so far
	int   sentCount = 0;
	int   takenCount = 0;
	// Cycles with the result slot stalled and a request turned away
	int   fullWaits = 0;

	divUnit i_dut (
		.clk(clk), .rst(rst), .abort(abort),
		.reqValid(reqValid), .reqReady(reqReady), .reqFunc(reqFunc),
		.reqA(reqA), .reqB(reqB),
		.resValid(resValid), .resReady(resReady), .resData(resData),
		.resDivByZero(resDivByZero), .resIllegal(resIllegal)
	);

	// 20 ns period
	always #10 clk = ~clk;

	always @(negedge clk) begin
		if (!rst && resValid && !resReady && reqValid && !reqReady) begin
			fullWaits++;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			failRun($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Drive point, just after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic loadVectors();
		int         fd;
		string      line;
		logic [3:0] tMode;
		func_t      tFunc;
		word_t      tA;
		word_t      tB;
		word_t      tExp;
		logic       tDbz;
		logic       tIll;
		fd = $fopen("tests/divUnit_input.txt", "r");
		if (fd == 0) begin
			failRun("could not open the vector file tests/divUnit_input.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Comment and blank lines give fewer than seven fields
			if ($sscanf(line, "%h %h %h %h %h %h %h",
					tMode, tFunc, tA, tB, tExp, tDbz, tIll) == 7) begin
				vMode.push_back(tMode);
				vFunc.push_back(tFunc);
				vA.push_back(tA);
				vB.push_back(tB);
				vExp.push_back(tExp);
				vDbz.push_back(tDbz);
				vIll.push_back(tIll);
			end
		end
		$fclose(fd);
		nVec = vMode.size();
		loaded = 1'b1;
	endtask

	// ============================================================
	// Producer and consumer
	// ============================================================

	// Hold the request until reqReady was high before an edge
	task automatic sendReq(input func_t f, input word_t x, input word_t y);
		logic taken;
		reqValid = 1'b1;
		reqFunc = f;
		reqA = x;
		reqB = y;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = reqReady;
			nextCycle();
		end
		reqValid = 1'b0;
	endtask

	// One in the divider, one pending in decode, both dropped
	task automatic abortRun();
		repeat (4) nextCycle();
		abort = 1'b1;
		nextCycle();
		abort = 1'b0;
		repeat (divWidth + 8) begin
			@(negedge clk);
			checkFlag("resValid", resValid, 1'b0);
		end
		nextCycle();
	endtask

	task automatic produce();
		for (int i = 0; i < nVec; i++) begin
			// Abort pair starts from an empty unit
			if (vMode[i] == 4'h2) begin
				wait (takenCount == sentCount);
				nextCycle();
			end
			sendReq(vFunc[i], vA[i], vB[i]);
			if (vMode[i] < 4'h2) begin
				sentCount++;
			end
			if (vMode[i] == 4'h3) begin
				abortRun();
			end
		end
	endtask

	task automatic consume();
		int unsigned stall;
		for (int j = 0; j < nVec; j++) begin
			// Aborted requests never give a result
			if (vMode[j] < 4'h2) begin
				resReady = vMode[j] != 4'h1;
				do begin
					@(negedge clk);
				end while (!resValid);
				if (vMode[j] == 4'h1) begin
					stall = $urandom % 8;
					repeat (stall) @(negedge clk);
					nextCycle();
					resReady = 1'b1;
					@(negedge clk);
				end
				checkWord("resData", resData, vExp[j]);
				checkFlag("resDivByZero", resDivByZero, vDbz[j]);
				checkFlag("resIllegal", resIllegal, vIll[j]);
				nextCycle();
				takenCount++;
			end
		end
	endtask

	// ============================================================
	// Run control
	// ============================================================

	initial begin
		rst = 1'b1;
		abort = 1'b0;
		reqValid = 1'b0;
		reqFunc = '0;
		reqA = '0;
		reqB = '0;
		resReady = 1'b0;
		void'($urandom(27));
		loadVectors();
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		checkFlag("reqReady", reqReady, 1'b1);
		checkFlag("resValid", resValid, 1'b0);
		nextCycle();
		fork
			produce();
			consume();
		join
		if (fullWaits == 0) begin
			failRun("reqReady never dropped while the result slot was stalled");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

	// Budget per vector plus 100 cycles of margin
	initial begin
		wait (loaded);
		#(nVec * (divWidth + 10) * 20 + 2000);
		failRun("timeout, results stopped coming from the DUT");
	end

	initial begin
		wait (i_dut.u_asserts.failCount != 0);
		failRun("a protocol assertion on the DUT failed");
	end

endmodule

`default_nettype wire

//--- tests/divUnit_asserts.sv
// Divide unit protocol assertions
`timescale 1ns/1ns
`default_nettype none

module divUnit_asserts (
	input wire logic          clk,
	input wire logic          rst,
	input wire logic          reqValid,
	input wire logic          reqReady,
	input wire divPkg::func_t reqFunc,
	input wire divPkg::word_t reqA,
	input wire divPkg::word_t reqB,
	input wire logic          resValid,
	input wire logic          resReady,
	input wire divPkg::word_t resData,
	input wire logic          ld,
	input wire logic          idle,
	input wire logic          done
);
	import divPkg::*;

	// Failed assertions so far
	int failCount = 0;

	// Request payload held while it waits
	reqHeld: assert property (@(posedge clk) disable iff (rst)
		reqValid && !reqReady |=> reqValid && $stable(reqFunc) && $stable(reqA) && $stable(reqB))
	else begin
		$error("request changed while reqValid waited");
		failCount++;
	end

	// Result held under back-pressure
	resHeld: assert property (@(posedge clk) disable iff (rst)
		resValid && !resReady |=> resValid && $stable(resData))
	else begin
		$error("result changed while resValid waited");
		failCount++;
	end

	// Iterations plus sign step after ld, then the done cycle
	doneTime: assert property (@(posedge clk) disable iff (rst)
		done |-> $past(ld, divWidth + 2))
	else begin
		$error("done outside the cycle after the last iteration");
		failCount++;
	end

	// The divider leaves idle on the edge that takes ld
	ldIdle: assert property (@(posedge clk) disable iff (rst)
		ld |-> idle ##1 !idle)
	else begin
		$error("ld while the divider was busy or ld not taken by the divider");
		failCount++;
	end

endmodule

bind divUnit divUnit_asserts u_asserts (
	.clk(clk), .rst(rst),
	.reqValid(reqValid), .reqReady(reqReady), .reqFunc(reqFunc),
	.reqA(reqA), .reqB(reqB),
	.resValid(resValid), .resReady(resReady), .resData(resData),
	.ld(ld), .idle(idle), .done(done)
);

`default_nettype wire

//--- tests/divUnit_input.txt
// mode func a b expected divByZero illegal, all hex
// mode 0 free consumer, 1 stalled consumer, 2 drain then send, 3 send then abort
0 1 0000000000000064 0000000000000007 000000000000000e 0 0
0 3 0000000000000064 0000000000000007 0000000000000002 0 0
0 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2 0 0
0 3 ffffffffffffff9c 0000000000000007 fffffffffffffffe 0 0
0 0 0000000000000064 fffffffffffffff9 fffffffffffffff2 0 0
0 3 0000000000000064 fffffffffffffff9 0000000000000002 0 0
0 0 ffffffffffffff9c fffffffffffffff9 000000000000000e 0 0
0 3 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe 0 0
0 0 8000000000000000 ffffffffffffffff 8000000000000000 0 0
0 2 ffffffffffffff9c 0000000000000007 fffffffffffffff2 0 0
0 5 ffffffffffffff9c fffffffffffffff9 ffffffffffffff9c 0 0
0 1 0000000000000064 0000000000000000 ffffffffffffffff 1 0
0 3 ffffffffffffff9c 0000000000000000 ffffffffffffff9c 1 0
0 0 ffffffffffffff9c 0000000000000000 0000000000000001 1 0
0 6 0000000000000064 0000000000000007 0000000000000000 0 1
0 7 0000000000000064 0000000000000007 0000000000000000 0 1
1 1 00000000000003e8 0000000000000021 000000000000001e 0 0
1 3 fffffffffffffc18 0000000000000021 fffffffffffffff6 0 0
1 0 fffffffffffffc18 0000000000000021 ffffffffffffffe2 0 0
1 5 fffffffffffffc18 0000000000000021 fffffffffffffff6 0 0
2 1 0000000000000064 0000000000000007 000000000000000e 0 0
3 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2 0 0
0 4 00000000000003e8 0000000000000021 000000000000000a 0 0
